/* logic/synth_pkg.sv */
`default_nettype none

package synth_pkg;

	// One voice per push button
	localparam int num_voices = 4;

	// Semitones per octave, shared by the period lookup and the note offsets
	localparam int octave_span = 12;

	// Shortest period a divider is allowed to count
	localparam int min_period = 2;

	// Semitones counted upward from the lowest C, a value of 0 means the voice is silent
	typedef logic [5:0] note_t;

	// Unsigned amplitude of one voice
	typedef logic [3:0] sample_t;

	// Number of clock cycles between two phase steps
	typedef logic [15:0] period_t;

	// Everything a single voice needs to know about what it should play
	typedef struct packed {
		note_t note;
		logic  wave_tri;
	} voice_ctrl_t;

	typedef voice_ctrl_t [num_voices-1:0] voice_ctrl_vec_t;

	typedef sample_t [num_voices-1:0] sample_vec_t;

	// Step periods of the lowest octave, C up to B
	// Each entry is 50 MHz divided by 64 steps per wave cycle and by the tone frequency
	localparam period_t base_period [octave_span] = '{
		16'd23890,
		16'd22549,
		16'd21283,
		16'd20088,
		16'd18961,
		16'd17897,
		16'd16892,
		16'd15944,
		16'd15049,
		16'd14205,
		16'd13407,
		16'd12655
	};

	// Step period of a note, each octave up halves the table value
	// The extra shift shortens every period by the same power of two
	function automatic period_t step_period(input note_t note, input int shift);
		int index;
		int octave;
		int semitone;
		int result;

		index = int'(note) - 1;
		// A silent note never gets counted, so it simply maps onto the lowest C
		if (index < 0)
		begin
			index = 0;
		end
		octave = index / octave_span;
		semitone = index % octave_span;
		result = int'(base_period[semitone]) >> (octave + shift);
		if (result < min_period)
		begin
			result = min_period;
		end
		return period_t'(result);
	endfunction

	// Base note of the major scale degree picked by the one-hot selector
	// Anything that is not exactly one-hot falls back to the tonic
	function automatic note_t degree_note(input logic [5:0] sel);
		note_t note;

		case (sel)
			6'b000001: note = note_t'(3);
			6'b000010: note = note_t'(5);
			6'b000100: note = note_t'(6);
			6'b001000: note = note_t'(8);
			6'b010000: note = note_t'(10);
			6'b100000: note = note_t'(12);
			default:   note = note_t'(1);
		endcase
		return note;
	endfunction

endpackage

`default_nettype wire

/* logic/key_scanner.sv */
`default_nettype none

module key_scanner
	import synth_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [num_voices-1:0] buttons,
	input  logic [5:0]            degree_sel,
	input  logic [num_voices-1:0] wave_sel,
	output voice_ctrl_vec_t       voice_ctrl
);

	// Registered copies of the board controls
	logic [num_voices-1:0] buttons_q;
	logic [5:0]            degree_q;
	logic [num_voices-1:0] wave_q;

	// Note of the lowest voice before gating
	note_t base_note;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			buttons_q <= '0;
			degree_q <= '0;
			wave_q <= '0;
		end
		else
		begin
			buttons_q <= buttons;
			degree_q <= degree_sel;
			wave_q <= wave_sel;
		end
	end

	assign base_note = degree_note(degree_q);

	// Voice i plays the selected degree i octaves above the base note
	// The highest note is 12 + 3 * 12 = 48, so it always fits in note_t
	always_comb
	begin
		for (int i = 0; i < num_voices; i++)
		begin
			if (buttons_q[i])
			begin
				voice_ctrl[i].note = base_note + note_t'(octave_span * i);
			end
			else
			begin
				voice_ctrl[i].note = '0;
			end
			// The waveform select follows its voice even while silent
			voice_ctrl[i].wave_tri = wave_q[i];
		end
	end

endmodule

`default_nettype wire

/* logic/tone_divider.sv */
`default_nettype none

module tone_divider
	import synth_pkg::*;
#(
	parameter int TONE_SHIFT = 0
)
(
	input  logic  clk,
	input  logic  rst_n,
	input  note_t note,
	output logic  step
);

	// Cycles left until the next phase step
	period_t count;

	// Note seen on the previous cycle, used to spot a change
	note_t last_note;

	// Period that belongs to the current note
	period_t reload;

	logic note_changed;

	assign reload = step_period(note, TONE_SHIFT);
	assign note_changed = (note != last_note);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			count <= '0;
			last_note <= '0;
			step <= 1'b0;
		end
		else
		begin
			last_note <= note;
			if (note == '0)
			begin
				// Silent voice, the counter waits
				count <= '0;
				step <= 1'b0;
			end
			else if (note_changed)
			begin
				// A new note starts a full period from now
				count <= reload;
				step <= 1'b0;
			end
			else if (count <= period_t'(1))
			begin
				// Expiry, pulse once and start the next period
				count <= reload;
				step <= 1'b1;
			end
			else
			begin
				count <= count - period_t'(1);
				step <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/wave_shaper.sv */
`default_nettype none

module wave_shaper
	import synth_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  voice_ctrl_t ctrl,
	input  logic        step,
	output sample_t     sample
);

	// Position within one wave cycle of 64 steps
	logic [5:0] phase;

	// Distance from the end of the cycle, used on the falling half of the triangle
	logic [5:0] falling;

	// Sample for the current phase before it is registered
	sample_t shaped;

	assign falling = 6'd63 - phase;

	always_comb
	begin
		if (ctrl.wave_tri)
		begin
			// Rises 0 to 15 over the first half, then falls back to 0
			if (!phase[5])
			begin
				shaped = phase[4:1];
			end
			else
			begin
				shaped = falling[4:1];
			end
		end
		else
		begin
			// Square wave is high for the first half of the cycle
			shaped = phase[5] ? sample_t'(0) : sample_t'(15);
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			phase <= '0;
			sample <= '0;
		end
		else if (ctrl.note == '0)
		begin
			phase <= '0;
			sample <= '0;
		end
		else
		begin
			// Phase wraps from 63 to 0 on its own
			if (step)
			begin
				phase <= phase + 6'd1;
			end
			sample <= shaped;
		end
	end

endmodule

`default_nettype wire

/* logic/voice_mixer.sv */
`default_nettype none

module voice_mixer
	import synth_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  sample_vec_t samples,
	output logic [7:0]  audio_out
);

	// Four samples of at most 15 add up to at most 60
	logic [5:0] sum;

	always_comb
	begin
		sum = '0;
		for (int i = 0; i < num_voices; i++)
		begin
			sum = sum + 6'(samples[i]);
		end
	end

	// Scaling by 4 puts the full mix at 240, just under the 8-bit limit
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			audio_out <= '0;
		end
		else
		begin
			audio_out <= {sum, 2'b00};
		end
	end

endmodule

`default_nettype wire

/* logic/synth_top.sv */
`default_nettype none

module synth_top
	import synth_pkg::*;
#(
	parameter int TONE_SHIFT = 0
)
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [num_voices-1:0] buttons,
	input  logic [5:0]            degree_sel,
	input  logic [num_voices-1:0] wave_sel,
	output logic [7:0]            audio_out
);

	// Notes and waveform selects for every voice
	voice_ctrl_vec_t voice_ctrl;

	// One phase step pulse per voice
	logic [num_voices-1:0] step;

	// Per-voice samples going into the mixer
	sample_vec_t samples;

	key_scanner u_key_scanner (
		.clk        (clk),
		.rst_n      (rst_n),
		.buttons    (buttons),
		.degree_sel (degree_sel),
		.wave_sel   (wave_sel),
		.voice_ctrl (voice_ctrl)
	);

	// Each voice gets its own divider and shaper
	for (genvar i = 0; i < num_voices; i++)
	begin : g_voice
		tone_divider #(
			.TONE_SHIFT (TONE_SHIFT)
		) u_tone_divider (
			.clk   (clk),
			.rst_n (rst_n),
			.note  (voice_ctrl[i].note),
			.step  (step[i])
		);

		wave_shaper u_wave_shaper (
			.clk    (clk),
			.rst_n  (rst_n),
			.ctrl   (voice_ctrl[i]),
			.step   (step[i]),
			.sample (samples[i])
		);
	end

	voice_mixer u_voice_mixer (
		.clk       (clk),
		.rst_n     (rst_n),
		.samples   (samples),
		.audio_out (audio_out)
	);

endmodule

`default_nettype wire

/* verif/synth_tb.sv */
`default_nettype none

module synth_tb
	import synth_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ns;

	localparam int tone_shift = 6;

	logic clk = 1'b0;
	logic rst_n;
	logic [3:0] buttons;
	logic [5:0] degree_sel;
	logic [3:0] wave_sel;
	logic [7:0] audio_out;

	integer seed;
	int cycle;
	int limit;
	int rise_count;
	int last_rise;
	int rise_gap;
	logic expect_silent;
	logic [7:0] prev_audio;

	synth_top #(.TONE_SHIFT(tone_shift)) dut (
		.clk(clk), .rst_n(rst_n),
		.buttons(buttons), .degree_sel(degree_sel),
		.wave_sel(wave_sel), .audio_out(audio_out)
	);

	always #50 clk = ~clk;

	// Voice i plays the selected degree i octaves up
	function automatic note_t voice_note(input int voice, input logic [5:0] sel);
		return degree_note(sel) + note_t'(12 * voice);
	endfunction

	function automatic int wave_span(input note_t note, input int waves);
		return waves * 64 * int'(step_period(note, tone_shift)) + 16;
	endfunction

	function automatic sample_t exp_sample(input logic [5:0] phase, input logic wave);
		if (!wave)
			return (phase < 6'd32) ? sample_t'(15) : sample_t'(0);
		return (phase < 6'd32) ? sample_t'(phase / 2) : sample_t'((63 - phase) / 2);
	endfunction

	function automatic logic [7:0] exp_mix(input logic [3:0][5:0] phases, input logic [3:0] wave);
		int total;
		total = 0;
		for (int i = 0; i < 4; i++)
			total += int'(exp_sample(phases[i], wave[i]));
		return 8'(4 * total);
	endfunction

	function automatic int planned_cycles();
		int total;
		total = 64;
		for (int v = 0; v < 4; v++)
		begin
			for (int c = 0; c < 7; c++)
				total += wave_span(voice_note(v, 6'(1 << c)), 3);
			total += wave_span(voice_note(v, 6'b000100), 2);
		end
		// Random mixes and note changes are bounded by the lowest note
		total += 3 * wave_span(note_t'(1), 1) + 2 * wave_span(note_t'(1), 6);
		return total;
	endfunction

	task automatic report_fail(input string msg);
		$display("[FAIL] %0t: %s", $time, msg);
		$display("TB FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_audio(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp)
			report_fail($sformatf("%s: audio_out %0d, expected %0d", what, got, exp));
	endtask

	task automatic check_period(input period_t got, input period_t exp, input string what);
		if (got !== exp)
			report_fail($sformatf("%s: %0d cycles, expected %0d", what, got, exp));
	endtask

	task automatic press(input logic [3:0] on, input logic [5:0] sel, input logic [3:0] wave);
		@(negedge clk);
		buttons = on;
		degree_sel = sel;
		wave_sel = wave;
	endtask

	// Audio must be gone three cycles after the buttons drop
	task automatic release_all();
		@(negedge clk);
		buttons = '0;
		repeat (3) @(negedge clk);
		expect_silent = 1'b1;
		repeat (8) @(negedge clk);
		expect_silent = 1'b0;
	endtask

	// Rises up to the settle count still carry the start or the old note
	// The two gaps after them are full wave cycles
	task automatic measure_gaps(input period_t step, input int settle, input string what);
		int n;
		n = rise_count;
		wait (rise_count >= n + settle);
		for (int k = 1; k <= 2; k++)
		begin
			wait (rise_count >= n + settle + k);
			check_period(period_t'(rise_gap), period_t'(64 * step), what);
		end
	endtask

	task automatic square_pitch(input int voice, input logic [5:0] sel, input logic [5:0] next_sel);
		press(4'(1 << voice), sel, 4'b0000);
		// The first wave cycle out of silence is stretched by the divider and shaper stages
		measure_gaps(step_period(voice_note(voice, sel), tone_shift), 2, "square pitch");
		if (next_sel != sel)
		begin
			@(negedge clk);
			degree_sel = next_sel;
			measure_gaps(step_period(voice_note(voice, next_sel), tone_shift), 1, "changed pitch");
		end
		release_all();
	endtask

	task automatic trace_triangle(input int voice, input logic [5:0] sel);
		period_t step;
		int n;
		step = step_period(voice_note(voice, sel), tone_shift);
		press(4'(1 << voice), sel, 4'(1 << voice));
		n = rise_count;
		// First nonzero level belongs to phase 2
		wait (rise_count > n);
		@(negedge clk);
		for (int k = 0; k < 64; k++)
		begin
			check_audio(audio_out, {exp_sample(6'(k + 2), 1'b1), 2'b00}, "triangle level");
			repeat (step) @(negedge clk);
		end
		release_all();
	endtask

	task automatic mix_random();
		logic [5:0] sel;
		logic [3:0] wave;
		period_t step [4];
		logic [3:0][5:0] phases;
		// A shift of 6 yields the invalid all-zero selector
		sel = 6'(1 << ($unsigned($random(seed)) % 7));
		wave = 4'($random(seed));
		for (int i = 0; i < 4; i++)
			step[i] = step_period(voice_note(i, sel), tone_shift);
		press(4'b1111, sel, wave);
		// Phases start moving one period after the divider reload, plus shaper and mixer stages
		for (int j = 1; j <= 64 * step[0] + 5; j++)
		begin
			@(negedge clk);
			if (j >= 5)
			begin
				for (int i = 0; i < 4; i++)
					phases[i] = 6'((j - 5) / step[i]);
				check_audio(audio_out, exp_mix(phases, wave), "four-voice mix");
			end
		end
		release_all();
	endtask

	always @(posedge clk)
	begin
		cycle = cycle + 1;
		if (cycle > limit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", limit);
			$display("TB FAILED");
			$fatal(1, "timeout");
		end
		else
		begin
			if (rst_n)
			begin
				if (audio_out > 8'd240 || audio_out[1:0] !== 2'b00)
					report_fail($sformatf("audio_out %0d is out of range", audio_out));
				if (expect_silent)
					check_audio(audio_out, 8'd0, "silent output");
				if (prev_audio == 8'd0 && audio_out != 8'd0)
				begin
					rise_gap = cycle - last_rise;
					last_rise = cycle;
					rise_count++;
				end
			end
			prev_audio = audio_out;
		end
	end

	initial
	begin
		seed = 32'he550687f;
		rst_n = 1'b0;
		buttons = '0;
		degree_sel = '0;
		wave_sel = '0;
		expect_silent = 1'b0;
		prev_audio = '0;
		cycle = 0;
		rise_count = 0;
		last_rise = 0;
		rise_gap = 0;
		limit = 2 * planned_cycles();
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		expect_silent = 1'b1;
		repeat (16) @(negedge clk);
		expect_silent = 1'b0;
		for (int v = 0; v < 4; v++)
			for (int c = 0; c < 7; c++)
				square_pitch(v, 6'(1 << c), 6'(1 << c));
		for (int v = 0; v < 4; v++)
			trace_triangle(v, 6'b000100);
		repeat (3) mix_random();
		square_pitch(1, 6'b000001, 6'b100000);
		square_pitch(2, 6'b010000, 6'b000000);
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* synth_top.f */
logic/synth_pkg.sv
logic/key_scanner.sv
logic/tone_divider.sv
logic/wave_shaper.sv
logic/voice_mixer.sv
logic/synth_top.sv
verif/synth_tb.sv
